// File: common/cpu_types_pkg.sv
package cpu_types_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // data word, also used for every byte address
  typedef logic [31:0] word_t;

  // register file index
  typedef logic [4:0]  regbits_t;

  // ------------------------------------------------------------------------
  // instruction encodings
  // ------------------------------------------------------------------------

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // function field of RTYPE, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    SLT  = 6'b101010
  } funct_t;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } aluop_t;

endpackage

// File: datapath/alu.sv
`timescale 1ns/10ps

module alu import cpu_types_pkg::*; (
  input  aluop_t     op,
  input  word_t      port_a,
  input  word_t      port_b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       zero
);

  always_comb begin
    case (op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      ALU_XOR: result = port_a ^ port_b;
      // signed compare
      ALU_SLT: result = {31'd0, $signed(port_a) < $signed(port_b)};
      // shifts take rt on port b
      ALU_SLL: result = port_b << shamt;
      ALU_SRL: result = port_b >> shamt;
      // immediate passes through, moved up in writeback
      ALU_LUI: result = port_b;
      default: result = '0;
    endcase
  end

  // branch compare flag
  assign zero = (result == '0);

endmodule

// File: datapath/register_file.sv
`timescale 1ns/10ps

module register_file import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen,
  input  regbits_t wsel,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  // r0 has no storage
  word_t regs [1:31];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // a read of the register being written sees the new value
  assign rdat1 = (rsel1 == '0) ? '0 :
                 (wen && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (rsel2 == '0) ? '0 :
                 (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// File: datapath/control_unit.sv
`timescale 1ns/10ps

module control_unit import cpu_types_pkg::*; (
  input  word_t       instr,
  output opcode_t     opcode,
  output regbits_t    rs,
  output regbits_t    rt,
  output regbits_t    rd,
  output logic [4:0]  shamt,
  output logic [15:0] imm,
  output aluop_t      aluop,
  output logic        alu_src,
  output logic        reg_dst,
  output logic        reg_wr,
  output logic        mem_to_reg,
  output logic        dren,
  output logic        dwen,
  output logic        ext_op,
  output logic        beq,
  output logic        bne,
  output logic        jump,
  output logic        jal,
  output logic        jr,
  output logic        lui,
  output logic        halt_op
);

  funct_t funct;

  // instruction fields
  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign imm    = instr[15:0];

  always_comb begin
    // anything not matched below decodes as a no-op
    aluop      = ALU_ADD;
    alu_src    = 1'b0;
    reg_dst    = 1'b0;
    reg_wr     = 1'b0;
    mem_to_reg = 1'b0;
    dren       = 1'b0;
    dwen       = 1'b0;
    ext_op     = 1'b0;
    beq        = 1'b0;
    bne        = 1'b0;
    jump       = 1'b0;
    jal        = 1'b0;
    jr         = 1'b0;
    lui        = 1'b0;
    halt_op    = 1'b0;

    case (opcode)
      RTYPE: begin
        reg_dst = 1'b1;
        reg_wr  = 1'b1;
        case (funct)
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          XOR:     aluop = ALU_XOR;
          SLT:     aluop = ALU_SLT;
          SLL:     aluop = ALU_SLL;
          SRL:     aluop = ALU_SRL;
          JR: begin
            reg_wr = 1'b0;
            jr     = 1'b1;
          end
          default: reg_wr = 1'b0;
        endcase
      end
      // immediates
      ADDIU: begin
        {alu_src, reg_wr, ext_op} = 3'b111;
      end
      SLTI: begin
        {alu_src, reg_wr, ext_op} = 3'b111;
        aluop = ALU_SLT;
      end
      ANDI: begin
        {alu_src, reg_wr} = 2'b11;
        aluop = ALU_AND;
      end
      ORI: begin
        {alu_src, reg_wr} = 2'b11;
        aluop = ALU_OR;
      end
      LUI: begin
        {alu_src, reg_wr, lui} = 3'b111;
        aluop = ALU_LUI;
      end
      // word loads and stores
      LW: begin
        {alu_src, reg_wr, ext_op, mem_to_reg, dren} = 5'b11111;
      end
      SW: begin
        {alu_src, ext_op, dwen} = 3'b111;
      end
      // branches compare by subtraction
      BEQ: begin
        {ext_op, beq} = 2'b11;
        aluop = ALU_SUB;
      end
      BNE: begin
        {ext_op, bne} = 2'b11;
        aluop = ALU_SUB;
      end
      J:    jump = 1'b1;
      JAL: begin
        {jal, reg_wr} = 2'b11;
      end
      HALT: halt_op = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: datapath/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit import cpu_types_pkg::*; (
  input  regbits_t dec_rs,
  input  regbits_t dec_rt,
  input  logic     dec_uses_rt,
  input  regbits_t ex_wsel,
  input  logic     ex_regwr,
  input  regbits_t mem_wsel,
  input  logic     mem_regwr,
  input  logic     mem_take,
  output logic     pc_write,
  output logic     fd_stall,
  output logic     de_flush,
  output logic     fd_flush,
  output logic     em_flush
);

  logic ex_dep;
  logic mem_dep;
  logic raw;

  // writers to r0 never cause a dependence
  assign ex_dep  = ex_regwr && ex_wsel != '0 &&
                   (ex_wsel == dec_rs || (dec_uses_rt && ex_wsel == dec_rt));
  assign mem_dep = mem_regwr && mem_wsel != '0 &&
                   (mem_wsel == dec_rs || (dec_uses_rt && mem_wsel == dec_rt));
  assign raw     = ex_dep || mem_dep;

  always_comb begin
    pc_write = 1'b1;
    fd_stall = 1'b0;
    de_flush = 1'b0;
    fd_flush = 1'b0;
    em_flush = 1'b0;
    if (mem_take) begin
      // the younger three are on the wrong path
      fd_flush = 1'b1;
      de_flush = 1'b1;
      em_flush = 1'b1;
    end else if (raw) begin
      // hold decode, bubble into execute
      pc_write = 1'b0;
      fd_stall = 1'b1;
      de_flush = 1'b1;
    end
  end

endmodule

// File: datapath/datapath.sv
`timescale 1ns/10ps

module datapath import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  logic  dhit,
  input  word_t imemload,
  input  word_t dmemload,
  output logic  imemREN,
  output word_t imemaddr,
  output logic  dmemREN,
  output logic  dmemWEN,
  output word_t dmemaddr,
  output word_t dmemstore,
  output logic  halt
);

  // decode outputs
  opcode_t     dec_opcode;
  regbits_t    dec_rs, dec_rt, dec_rd, dec_wsel;
  logic [4:0]  dec_shamt;
  logic [15:0] dec_imm;
  aluop_t      dec_aluop;
  logic        dec_alu_src, dec_reg_dst, dec_reg_wr, dec_mem_to_reg;
  logic        dec_dren, dec_dwen, dec_ext_op, dec_beq, dec_bne;
  logic        dec_jump, dec_jal, dec_jr, dec_lui, dec_halt, dec_uses_rt;
  word_t       dec_ext, rdat1, rdat2;

  // fetch and fetch/decode
  word_t pc, pc_plus4, fd_instr, fd_pcp4;

  // decode/execute
  logic        de_reg_wr, de_mem_to_reg, de_dren, de_dwen, de_beq, de_bne;
  logic        de_jump, de_jal, de_jr, de_lui, de_halt, de_alu_src;
  aluop_t      de_aluop;
  regbits_t    de_wsel;
  logic [4:0]  de_shamt;
  logic [25:0] de_jaddr;
  word_t       de_pcp4, de_rdat1, de_rdat2, de_ext;

  // execute/memory
  logic        em_reg_wr, em_mem_to_reg, em_dren, em_dwen, em_beq, em_bne;
  logic        em_jump, em_jal, em_jr, em_lui, em_halt, em_zero;
  regbits_t    em_wsel;
  logic [25:0] em_jaddr;
  word_t       em_pcp4, em_alu, em_rdat1, em_rdat2, em_ext;

  // memory/writeback
  logic        mw_reg_wr, mw_mem_to_reg, mw_jal, mw_lui, mw_halt;
  regbits_t    mw_wsel;
  word_t       mw_pcp4, mw_alu, mw_dload, wdat;

  word_t alu_b, alu_out, take_target;
  logic  alu_zero, mem_op, adv, mem_take, stop_data;
  logic  pc_write, fd_stall, de_flush, fd_flush, em_flush;

  control_unit u_ctrl (
    .instr(fd_instr), .opcode(dec_opcode), .rs(dec_rs), .rt(dec_rt), .rd(dec_rd),
    .shamt(dec_shamt), .imm(dec_imm), .aluop(dec_aluop), .alu_src(dec_alu_src),
    .reg_dst(dec_reg_dst), .reg_wr(dec_reg_wr), .mem_to_reg(dec_mem_to_reg),
    .dren(dec_dren), .dwen(dec_dwen), .ext_op(dec_ext_op), .beq(dec_beq),
    .bne(dec_bne), .jump(dec_jump), .jal(dec_jal), .jr(dec_jr), .lui(dec_lui),
    .halt_op(dec_halt)
  );

  register_file u_rf (
    .CLK(CLK), .nRST(nRST), .wen(mw_reg_wr), .wsel(mw_wsel), .rsel1(dec_rs),
    .rsel2(dec_rt), .wdat(wdat), .rdat1(rdat1), .rdat2(rdat2)
  );

  alu u_alu (
    .op(de_aluop), .port_a(de_rdat1), .port_b(alu_b), .shamt(de_shamt),
    .result(alu_out), .zero(alu_zero)
  );

  hazard_unit u_hazard (
    .dec_rs(dec_rs), .dec_rt(dec_rt), .dec_uses_rt(dec_uses_rt),
    .ex_wsel(de_wsel), .ex_regwr(de_reg_wr), .mem_wsel(em_wsel),
    .mem_regwr(em_reg_wr), .mem_take(mem_take), .pc_write(pc_write),
    .fd_stall(fd_stall), .de_flush(de_flush), .fd_flush(fd_flush), .em_flush(em_flush)
  );

  // --------------------------------------------------------------------------
  // advance and memory requests
  // --------------------------------------------------------------------------

  // a load or store in memory waits on dhit, otherwise on the fetch
  assign mem_op = em_dren || em_dwen;
  assign adv    = mem_op ? dhit : ihit;

  // nothing past a halt may touch memory
  assign stop_data = halt || mw_halt;
  assign imemREN   = !halt;
  assign imemaddr  = pc;
  assign dmemREN   = em_dren && !stop_data;
  assign dmemWEN   = em_dwen && !stop_data;
  assign dmemaddr  = em_alu;
  assign dmemstore = em_rdat2;

  // --------------------------------------------------------------------------
  // decode and execute helpers
  // --------------------------------------------------------------------------

  assign pc_plus4    = pc + 32'd4;
  assign dec_ext     = dec_ext_op ? {{16{dec_imm[15]}}, dec_imm} : {16'h0000, dec_imm};
  assign dec_wsel    = dec_jal ? 5'd31 : (dec_reg_dst ? dec_rd : dec_rt);
  // rt is a source for rtype, branches and sw
  assign dec_uses_rt = (dec_opcode == RTYPE) || dec_beq || dec_bne || dec_dwen;
  assign alu_b       = de_alu_src ? de_ext : de_rdat2;

  // branch and jump resolution in memory
  assign mem_take = (em_beq && em_zero) || (em_bne && !em_zero) ||
                    em_jump || em_jal || em_jr;

  always_comb begin
    if (em_jr)
      take_target = em_rdat1;
    else if (em_jump || em_jal)
      take_target = {em_pcp4[31:28], em_jaddr, 2'b00};
    else
      take_target = em_pcp4 + {em_ext[29:0], 2'b00};
  end

  // --------------------------------------------------------------------------
  // PC and control state of the stage registers
  // --------------------------------------------------------------------------

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc       <= PC_INIT;
      fd_instr <= '0;
      {de_reg_wr, de_mem_to_reg, de_dren, de_dwen, de_beq, de_bne,
       de_jump, de_jal, de_jr, de_lui, de_halt, de_alu_src} <= '0;
      {em_reg_wr, em_mem_to_reg, em_dren, em_dwen, em_beq, em_bne,
       em_jump, em_jal, em_jr, em_lui, em_halt} <= '0;
      {mw_reg_wr, mw_mem_to_reg, mw_jal, mw_lui, mw_halt} <= '0;
    end else if (adv) begin
      // no fetch completed when dhit drove the advance
      if (mem_take)
        pc <= take_target;
      else if (pc_write && !mem_op)
        pc <= pc_plus4;

      if (fd_flush)
        fd_instr <= '0;
      else if (!fd_stall)
        fd_instr <= mem_op ? '0 : imemload;

      if (de_flush)
        {de_reg_wr, de_mem_to_reg, de_dren, de_dwen, de_beq, de_bne,
         de_jump, de_jal, de_jr, de_lui, de_halt, de_alu_src} <= '0;
      else
        {de_reg_wr, de_mem_to_reg, de_dren, de_dwen, de_beq, de_bne,
         de_jump, de_jal, de_jr, de_lui, de_halt, de_alu_src} <=
          {dec_reg_wr, dec_mem_to_reg, dec_dren, dec_dwen, dec_beq, dec_bne,
           dec_jump, dec_jal, dec_jr, dec_lui, dec_halt, dec_alu_src};

      if (em_flush)
        {em_reg_wr, em_mem_to_reg, em_dren, em_dwen, em_beq, em_bne,
         em_jump, em_jal, em_jr, em_lui, em_halt} <= '0;
      else
        {em_reg_wr, em_mem_to_reg, em_dren, em_dwen, em_beq, em_bne,
         em_jump, em_jal, em_jr, em_lui, em_halt} <=
          {de_reg_wr, de_mem_to_reg, de_dren, de_dwen, de_beq, de_bne,
           de_jump, de_jal, de_jr, de_lui, de_halt};

      {mw_reg_wr, mw_mem_to_reg, mw_jal, mw_lui, mw_halt} <=
        {em_reg_wr, em_mem_to_reg, em_jal, em_lui, em_halt};
    end
  end

  // payload follows the control bits, bubbles leave it stale
  always_ff @(posedge CLK) begin
    if (adv) begin
      if (!fd_stall)
        fd_pcp4 <= pc_plus4;
      {de_aluop, de_wsel, de_shamt, de_jaddr} <=
        {dec_aluop, dec_wsel, dec_shamt, fd_instr[25:0]};
      {de_pcp4, de_rdat1, de_rdat2, de_ext} <= {fd_pcp4, rdat1, rdat2, dec_ext};
      {em_wsel, em_zero, em_jaddr} <= {de_wsel, alu_zero, de_jaddr};
      {em_pcp4, em_alu, em_rdat1, em_rdat2, em_ext} <=
        {de_pcp4, alu_out, de_rdat1, de_rdat2, de_ext};
      mw_wsel  <= em_wsel;
      mw_pcp4  <= em_pcp4;
      mw_alu   <= em_alu;
      mw_dload <= dmemload;
    end
  end

  // --------------------------------------------------------------------------
  // writeback and halt
  // --------------------------------------------------------------------------

  always_comb begin
    if (mw_lui)
      wdat = {mw_alu[15:0], 16'h0000};
    else if (mw_jal)
      wdat = mw_pcp4;
    else if (mw_mem_to_reg)
      wdat = mw_dload;
    else
      wdat = mw_alu;
  end

  // sticky until reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      halt <= 1'b0;
    else if (mw_halt)
      halt <= 1'b1;
  end

endmodule

// File: design/request_arbiter.sv
`timescale 1ns/10ps

module request_arbiter import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  imemREN,
  input  word_t imemaddr,
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  output logic  ihit,
  output logic  dhit,
  output word_t imemload,
  output word_t dmemload,
  output logic  mem_ren,
  output logic  mem_wen,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata,
  input  logic  mem_ready
);

  typedef enum logic {IDLE, DATA_DONE} state_t;

  state_t state;
  logic   d_sel;

  // data wins, except right after a data access while the fetch resumes
  assign d_sel = (dmemREN || dmemWEN) && state == IDLE;

  assign mem_ren   = d_sel ? dmemREN : imemREN;
  assign mem_wen   = d_sel && dmemWEN;
  assign mem_addr  = d_sel ? dmemaddr : imemaddr;
  assign mem_wdata = dmemstore;

  assign dhit     = d_sel && mem_ready;
  assign ihit     = !d_sel && imemREN && mem_ready;
  assign imemload = mem_rdata;
  assign dmemload = mem_rdata;

  // leave DATA_DONE once the fetch is done, so a fetch is never cut short
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST)
      state <= IDLE;
    else if (state == IDLE && dhit)
      state <= DATA_DONE;
    else if (state == DATA_DONE && (ihit || !imemREN))
      state <= IDLE;
  end

endmodule

// File: design/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  output logic  mem_ren,
  output logic  mem_wen,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata,
  input  logic  mem_ready,
  output logic  halt
);

  logic  ihit, dhit, imemREN, dmemREN, dmemWEN;
  word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;

  datapath #(.PC_INIT(PC_INIT)) u_datapath (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .dhit(dhit), .imemload(imemload),
    .dmemload(dmemload), .imemREN(imemREN), .imemaddr(imemaddr),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .halt(halt)
  );

  // single memory port shared by fetch and data
  request_arbiter u_arbiter (
    .CLK(CLK), .nRST(nRST), .imemREN(imemREN), .imemaddr(imemaddr),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .ihit(ihit), .dhit(dhit), .imemload(imemload),
    .dmemload(dmemload), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .mem_ready(mem_ready)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic CLK
);

  // 8 ns period, first rising edge at 4 ns
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

endmodule

// File: tests/tb_cpu_core.sv
`timescale 1ns/10ps

module tb_cpu_core import cpu_types_pkg::*; ();

  localparam word_t PROG_BASE   = 32'h0000_0080;
  localparam word_t DATA_BASE   = 32'h0000_0400;
  localparam int    MEM_WORDS   = 1024;
  localparam int    N_STORES    = 16;
  localparam int    EXEC_INSTRS = 46;
  localparam int    JAL_AT      = 43;
  localparam int    SUB_AT      = 50;
  localparam int    CLK_NS      = 8;
  localparam int    TIMEOUT_NS  = 20 * EXEC_INSTRS * 8 * CLK_NS;

  logic  CLK;
  logic  nRST;
  logic  mem_ren;
  logic  mem_wen;
  word_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;
  logic  mem_ready;
  logic  halt;

  word_t mem [MEM_WORDS];
  word_t exp_addr [N_STORES];
  word_t exp_data [N_STORES];
  int    prog_len;
  int    writes_seen = 0;

  tb_clock_gen u_clk (.CLK(CLK));

  cpu_core #(.PC_INIT(PROG_BASE)) dut (
    .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .mem_ready(mem_ready), .halt(halt)
  );

  // --------------------------------------------------------------------------
  // failure reporting and instruction encoding
  // --------------------------------------------------------------------------

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_error(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    stop_failed();
  endtask

  // untouched words read back as a marker mixed with their own address
  function automatic word_t fill_word(word_t addr);
    return addr ^ 32'hDEAD_0000;
  endfunction

  function automatic word_t prog_addr(int idx);
    return PROG_BASE + word_t'(4 * idx);
  endfunction

  // arguments in field order
  function automatic word_t rtype_word(funct_t f, int rs, int rt, int rd, int sh);
    return {RTYPE, regbits_t'(rs), regbits_t'(rt), regbits_t'(rd), sh[4:0], f};
  endfunction

  function automatic word_t itype_word(opcode_t op, int rs, int rt, int imm);
    return {op, regbits_t'(rs), regbits_t'(rt), imm[15:0]};
  endfunction

  function automatic word_t jtype_word(opcode_t op, word_t target);
    return {op, target[27:2]};
  endfunction

  task automatic emit(word_t w);
    mem[(PROG_BASE >> 2) + prog_len] = w;
    prog_len++;
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = fill_word(word_t'(i * 4));
    prog_len = 0;
    // alu and immediate operations
    emit(itype_word(ADDIU, 0, 1, 'h400));          // 0  addiu r1, r0, 0x400
    emit(itype_word(ADDIU, 0, 2, 25));             // 1  addiu r2, r0, 25
    emit(itype_word(ADDIU, 0, 3, -7));             // 2  addiu r3, r0, -7
    emit(itype_word(LUI, 0, 4, 'h1234));           // 3  lui   r4, 0x1234
    emit(itype_word(ORI, 4, 4, 'h5678));           // 4  ori   r4, r4, 0x5678
    emit(rtype_word(ADDU, 2, 3, 5, 0));            // 5  addu  r5, r2, r3
    emit(rtype_word(SUBU, 2, 3, 6, 0));            // 6  subu  r6, r2, r3
    emit(rtype_word(XOR, 4, 3, 7, 0));             // 7  xor   r7, r4, r3
    emit(rtype_word(AND, 4, 2, 8, 0));             // 8  and   r8, r4, r2
    emit(rtype_word(OR, 4, 2, 9, 0));              // 9  or    r9, r4, r2
    emit(rtype_word(SLT, 3, 2, 10, 0));            // 10 slt   r10, r3, r2
    emit(rtype_word(SLL, 0, 4, 11, 4));            // 11 sll   r11, r4, 4
    emit(rtype_word(SRL, 0, 4, 12, 8));            // 12 srl   r12, r4, 8
    emit(itype_word(SLTI, 2, 13, -1));             // 13 slti  r13, r2, -1
    emit(itype_word(ANDI, 4, 14, 'hFF0F));         // 14 andi  r14, r4, 0xff0f
    for (int r = 4; r <= 14; r++)
      emit(itype_word(SW, 1, r, 4 * (r - 4)));     // 15..25 sw rN, 4*(N-4)(r1)
    // load use and chained dependences
    emit(itype_word(LW, 1, 15, 4));                // 26 lw    r15, 4(r1)
    emit(rtype_word(ADDU, 15, 15, 16, 0));         // 27 addu  r16, r15, r15
    emit(rtype_word(ADDU, 16, 4, 16, 0));          // 28 addu  r16, r16, r4
    emit(itype_word(SW, 1, 16, 44));               // 29 sw    r16, 44(r1)
    emit(itype_word(LW, 0, 19, 'h7F0));            // 30 lw    r19, 0x7f0(r0)
    emit(itype_word(SW, 1, 19, 48));               // 31 sw    r19, 48(r1)
    // branches, skipped stores write zero to 60(r1)
    emit(itype_word(BEQ, 2, 3, 1));                // 32 beq   r2, r3, +1
    emit(itype_word(ADDIU, 0, 17, 'h11));          // 33 addiu r17, r0, 0x11
    emit(itype_word(BNE, 5, 5, 1));                // 34 bne   r5, r5, +1
    emit(itype_word(ADDIU, 17, 17, 'h22));         // 35 addiu r17, r17, 0x22
    emit(itype_word(BEQ, 5, 5, 1));                // 36 beq   r5, r5, +1
    emit(itype_word(SW, 1, 0, 60));                // 37 skipped
    emit(itype_word(BNE, 2, 3, 1));                // 38 bne   r2, r3, +1
    emit(itype_word(SW, 1, 0, 60));                // 39 skipped
    emit(itype_word(SW, 1, 17, 52));               // 40 sw    r17, 52(r1)
    emit(jtype_word(J, prog_addr(JAL_AT)));        // 41 j     43
    emit(itype_word(SW, 1, 0, 60));                // 42 skipped
    emit(jtype_word(JAL, prog_addr(SUB_AT)));      // 43 jal   50
    emit(itype_word(SW, 1, 31, 56));               // 44 sw    r31, 56(r1)
    emit(itype_word(SW, 1, 18, 60));               // 45 sw    r18, 60(r1)
    emit(itype_word(HALT, 0, 0, 0));               // 46 halt
    for (int i = 0; i < 3; i++)
      emit(32'h0000_0000);                         // 47..49 nop
    emit(itype_word(ADDIU, 0, 18, 'h77));          // 50 addiu r18, r0, 0x77
    emit(rtype_word(JR, 31, 0, 0, 0));             // 51 jr    r31
    emit(itype_word(SW, 1, 0, 60));                // 52 skipped
  endtask

  // --------------------------------------------------------------------------
  // memory model, 0 to 3 wait cycles per access
  // --------------------------------------------------------------------------

  initial begin
    int   waits;
    logic busy;
    logic wrote;
    void'($urandom(73));
    mem_ready = 1'b0;
    mem_rdata = '0;
    busy      = 1'b0;
    wrote     = 1'b0;
    waits     = 0;
    load_program();
    forever begin
      @(posedge CLK);
      #1;
      // a write shown with ready last cycle completed on this edge
      if (wrote)
        writes_seen++;
      wrote = 1'b0;
      if (!nRST || !(mem_ren || mem_wen)) begin
        mem_ready = 1'b0;
        busy      = 1'b0;
      end else begin
        if (!busy) begin
          waits = $urandom_range(3, 0);
          busy  = 1'b1;
        end
        if (waits == 0) begin
          mem_ready = 1'b1;
          busy      = 1'b0;
          if (mem_wen) begin
            mem[mem_addr[11:2]] = mem_wdata;
            wrote = 1'b1;
          end else begin
            mem_rdata = mem[mem_addr[11:2]];
          end
        end else begin
          mem_ready = 1'b0;
          waits--;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  assert property (@(posedge CLK) !nRST |->
    (!halt && !mem_wen && !dut.dmemREN && !dut.dmemWEN && mem_ren &&
     mem_addr == PROG_BASE))
    else report_error("reset state wrong or first fetch not at PC_INIT");

  assert property (@(posedge CLK) disable iff (!nRST)
    (mem_wen && mem_ready) |-> writes_seen < N_STORES)
    else report_error("store beyond the end of the expected list");

  assert property (@(posedge CLK) disable iff (!nRST)
    (mem_wen && mem_ready) |->
      (mem_addr == exp_addr[writes_seen] && mem_wdata == exp_data[writes_seen]))
    else report_error($sformatf("store %0d wrote %h to %h, expected %h to %h",
      writes_seen, $sampled(mem_wdata), $sampled(mem_addr),
      exp_data[writes_seen], exp_addr[writes_seen]));

  assert property (@(posedge CLK) disable iff (!nRST)
    $rose(halt) |-> writes_seen == N_STORES)
    else report_error("halt rose before the final store");

  assert property (@(posedge CLK) disable iff (!nRST) halt |-> (!mem_ren && !mem_wen))
    else report_error("memory request after halt");

  assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else report_error("halt dropped before reset");

  // --------------------------------------------------------------------------
  // reset, expected stores, end of run
  // --------------------------------------------------------------------------

  initial begin
    for (int i = 0; i < N_STORES; i++)
      exp_addr[i] = DATA_BASE + word_t'(4 * i);
    exp_data = '{
      32'h1234_5678, 32'h0000_0012, 32'h0000_0020, 32'hEDCB_A981,
      32'h0000_0018, 32'h1234_5679, 32'h0000_0001, 32'h2345_6780,
      32'h0012_3456, 32'h0000_0000, 32'h0000_5608, 32'h1234_569C,
      32'h0, 32'h0000_0033, 32'h0, 32'h0000_0077
    };
    // lw from an untouched word, then the link of jal
    exp_data[12] = fill_word(32'h0000_07F0);
    exp_data[14] = prog_addr(JAL_AT) + 32'd4;

    // clean falling edge for the asynchronous reset
    nRST = 1'b1;
    #1;
    nRST = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    nRST = 1'b1;

    wait (halt === 1'b1);
    // let the halt checks watch a few idle cycles
    repeat (8) @(posedge CLK);
    if (writes_seen != N_STORES) begin
      report_error($sformatf("%0d stores seen, %0d expected", writes_seen, N_STORES));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the core did not halt within %0d ns", TIMEOUT_NS);
    stop_failed();
  end

endmodule

// File: cpu_core.f
common/cpu_types_pkg.sv
datapath/alu.sv
datapath/register_file.sv
datapath/control_unit.sv
datapath/hazard_unit.sv
datapath/datapath.sv
design/request_arbiter.sv
design/cpu_core.sv
tests/tb_clock_gen.sv
tests/tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  # shared types before every user
  - common/cpu_types_pkg.sv
  - datapath/alu.sv
  - datapath/register_file.sv
  - datapath/control_unit.sv
  - datapath/hazard_unit.sv
  - datapath/datapath.sv
  - design/request_arbiter.sv
  - design/cpu_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_cpu_core.sv
